//--- build.f
logic/RasPkg.sv
logic/RasLinkIf.sv
logic/FetchEventSource.sv
logic/ReturnStack.sv
logic/PredictionSink.sv
logic/ReturnPredictorTop.sv
verification/ReturnPredictorTb.sv

//--- logic/FetchEventSource.sv
`timescale 1ns/100ps
`default_nettype none

module FetchEventSource (
    input logic clk,
    input logic rst,
    input logic inValid,
    output logic inReady,
    input logic [RasPkg::AddrWidth-1:0] inPc,
    input logic [RasPkg::OffsWidth-1:0] inOffs,
    input RasPkg::BranchType inType,
    input logic misprValid,
    input logic [RasPkg::FetchIdWidth-1:0] misprId,
    RasLinkIf.sender eventLink
);

    // Two-entry shift buffer whose head is slot 0
    RasPkg::FetchEvent slot [2];
    logic [1:0] count;
    logic [RasPkg::FetchIdWidth-1:0] nextId;
    logic [RasPkg::CreditWidth-1:0] credit;

    logic accept;
    logic sendNow;
    logic [RasPkg::FetchIdWidth-1:0] idForNew;
    logic wrSlot;
    RasPkg::FetchEvent newEvent;

    assign inReady = count != 2'd2;
    assign accept = inValid && inReady;
    assign sendNow = count != 2'd0 && credit != '0;

    // An event taken in the mispredict cycle already belongs to the new path
    assign idForNew = misprValid ? misprId + 1'b1 : nextId;
    assign wrSlot = (count == 2'd1) && !sendNow;

    always_comb begin
        newEvent.fetchId = idForNew;
        newEvent.pc = inPc;
        newEvent.offs = inOffs;
        newEvent.btype = inType;
    end

    assign eventLink.valid = sendNow;
    assign eventLink.payload = slot[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= 2'd0;
            nextId <= '0;
            credit <= eventLink.creditInit;
        end else begin
            credit <= RasPkg::nextCredit(credit, sendNow, eventLink.creditReturn);
            nextId <= idForNew + RasPkg::FetchIdWidth'(accept);
            if (misprValid) begin
                // Wrong-path events are dropped along with any head sent this cycle
                slot[0] <= newEvent;
                count <= {1'b0, accept};
            end else begin
                if (sendNow) begin
                    slot[0] <= slot[1];
                end
                if (accept) begin
                    slot[wrSlot] <= newEvent;
                end
                count <= count + 2'(accept) - 2'(sendNow);
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/PredictionSink.sv
`timescale 1ns/100ps
`default_nettype none

module PredictionSink (
    input logic clk,
    input logic rst,
    RasLinkIf.receiver predLink,
    output logic outValid,
    output logic [RasPkg::AddrWidth-1:0] outTarget,
    output logic [RasPkg::FetchIdWidth-1:0] outFetchId,
    input logic outReady
);

    RasPkg::ReturnPrediction fifo [RasPkg::LinkCredits];
    logic [RasPkg::BufIdxWidth-1:0] rdPtr;
    logic [RasPkg::BufIdxWidth-1:0] wrPtr;
    logic [RasPkg::CreditWidth-1:0] count;
    logic popNow;

    assign outValid = count != '0;
    assign outTarget = fifo[rdPtr].target;
    assign outFetchId = fifo[rdPtr].fetchId;
    assign popNow = outValid && outReady;

    // Each freed slot goes straight back to the sender as a credit
    assign predLink.creditReturn = popNow;
    assign predLink.creditInit = RasPkg::CreditWidth'(RasPkg::LinkCredits);

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (predLink.valid) begin
                fifo[wrPtr] <= predLink.payload;
                wrPtr <= wrPtr + 1'b1;
            end
            if (popNow) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + RasPkg::CreditWidth'(predLink.valid) - RasPkg::CreditWidth'(popNow);
        end
    end

endmodule

`default_nettype wire

//--- logic/RasLinkIf.sv
`timescale 1ns/100ps
`default_nettype none

// The receiver of this credit-based link accepts every valid transfer
interface RasLinkIf #(
    parameter type PayloadT = logic
);

    logic valid;
    PayloadT payload;
    logic creditReturn;
    // The sender loads this receive buffer depth into its counter at reset
    logic [RasPkg::CreditWidth-1:0] creditInit;

    modport sender (
        output valid,
        output payload,
        input creditReturn,
        input creditInit
    );

    modport receiver (
        input valid,
        input payload,
        output creditReturn,
        output creditInit
    );

endinterface

`default_nettype wire

//--- logic/RasPkg.sv
`default_nettype none

package RasPkg;

    localparam int AddrWidth = 31;
    localparam int OffsWidth = 2;
    localparam int FetchIdWidth = 5;
    localparam int StackDepth = 8;
    localparam int StackIdxWidth = 3;
    localparam int QueueDepth = 4;
    localparam int QueueIdxWidth = 2;
    localparam int LinkCredits = 2;
    localparam int CreditWidth = 2;
    // Pointer width of a LinkCredits-deep receive buffer
    localparam int BufIdxWidth = 1;

    typedef enum logic [1:0] {
        BrNone,
        BrCall,
        BrReturn
    } BranchType;

    typedef struct packed {
        logic [FetchIdWidth-1:0] fetchId;
        logic [AddrWidth-1:0] pc;
        logic [OffsWidth-1:0] offs;
        BranchType btype;
    } FetchEvent;

    typedef struct packed {
        logic [FetchIdWidth-1:0] fetchId;
        logic [AddrWidth-1:0] target;
        logic [StackIdxWidth-1:0] stackIdx;
    } ReturnPrediction;

    // One send takes a credit and one returned credit gives it back
    function automatic logic [CreditWidth-1:0] nextCredit(
        input logic [CreditWidth-1:0] count,
        input logic take,
        input logic give
    );
        logic [CreditWidth-1:0] result;
        result = count;
        if (take && !give) begin
            result = count - 1'b1;
        end else if (give && !take) begin
            result = count + 1'b1;
        end
        return result;
    endfunction

endpackage

`default_nettype wire

//--- logic/ReturnPredictorTop.sv
`timescale 1ns/100ps
`default_nettype none

module ReturnPredictorTop (
    input logic clk,
    input logic rst,
    input logic inValid,
    output logic inReady,
    input logic [RasPkg::AddrWidth-1:0] inPc,
    input logic [RasPkg::OffsWidth-1:0] inOffs,
    input RasPkg::BranchType inType,
    input logic [RasPkg::FetchIdWidth-1:0] commitId,
    input logic misprValid,
    input logic [RasPkg::FetchIdWidth-1:0] misprId,
    input logic [RasPkg::OffsWidth-1:0] misprOffs,
    output logic outValid,
    output logic [RasPkg::AddrWidth-1:0] outTarget,
    output logic [RasPkg::FetchIdWidth-1:0] outFetchId,
    input logic outReady
);

    RasLinkIf #(.PayloadT(RasPkg::FetchEvent)) eventLink ();
    RasLinkIf #(.PayloadT(RasPkg::ReturnPrediction)) predLink ();

    FetchEventSource u_FetchEventSource (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inReady(inReady),
        .inPc(inPc),
        .inOffs(inOffs),
        .inType(inType),
        .misprValid(misprValid),
        .misprId(misprId),
        .eventLink(eventLink.sender)
    );

    ReturnStack u_ReturnStack (
        .clk(clk),
        .rst(rst),
        .eventLink(eventLink.receiver),
        .predLink(predLink.sender),
        .commitId(commitId),
        .misprValid(misprValid),
        .misprId(misprId),
        .misprOffs(misprOffs)
    );

    PredictionSink u_PredictionSink (
        .clk(clk),
        .rst(rst),
        .predLink(predLink.receiver),
        .outValid(outValid),
        .outTarget(outTarget),
        .outFetchId(outFetchId),
        .outReady(outReady)
    );

endmodule

`default_nettype wire

//--- logic/ReturnStack.sv
`timescale 1ns/100ps
`default_nettype none

module ReturnStack (
    input logic clk,
    input logic rst,
    RasLinkIf.receiver eventLink,
    RasLinkIf.sender predLink,
    input logic [RasPkg::FetchIdWidth-1:0] commitId,
    input logic misprValid,
    input logic [RasPkg::FetchIdWidth-1:0] misprId,
    input logic [RasPkg::OffsWidth-1:0] misprOffs
);

    typedef struct packed {
        logic [RasPkg::AddrWidth-1:0] addr;
        logic [RasPkg::StackIdxWidth-1:0] idx;
        logic [RasPkg::FetchIdWidth-1:0] fetchId;
        logic [RasPkg::OffsWidth-1:0] offs;
    } RecEntry;

    logic [RasPkg::AddrWidth-1:0] rstack [RasPkg::StackDepth];
    logic [RasPkg::StackIdxWidth-1:0] rIdx;
    // Stack index recorded as each fetch ID is applied and read back by a mispredict
    logic [RasPkg::StackIdxWidth-1:0] idxTable [2**RasPkg::FetchIdWidth];

    // The recovery queue is written at qHead and holds its oldest entry at qTail
    RecEntry rq [RasPkg::QueueDepth];
    logic [RasPkg::QueueIdxWidth:0] qHead;
    logic [RasPkg::QueueIdxWidth:0] qTail;
    logic queueEmpty;
    logic queueFull;
    RecEntry qTop;
    RecEntry qOld;

    // Killed entries of the event receive buffer are popped but not applied
    RasPkg::FetchEvent evBuf [RasPkg::LinkCredits];
    logic evKill [RasPkg::LinkCredits];
    logic [RasPkg::BufIdxWidth-1:0] evRd;
    logic [RasPkg::BufIdxWidth-1:0] evWr;
    logic [RasPkg::CreditWidth-1:0] evCount;
    logic [RasPkg::CreditWidth-1:0] predCredit;

    logic recovering;
    logic [RasPkg::FetchIdWidth-1:0] recoveryId;
    logic [RasPkg::FetchIdWidth-1:0] recoveryBase;
    logic [RasPkg::OffsWidth-1:0] recoveryOffs;
    logic [RasPkg::FetchIdWidth-1:0] lastComId;

    RasPkg::FetchEvent head;
    logic arrive;
    logic pop;
    logic apply;
    logic isCall;
    logic isRet;
    logic restoreNow;
    logic [RasPkg::StackIdxWidth-1:0] pushIdx;
    logic [RasPkg::StackIdxWidth-1:0] nextIdx;
    logic [RasPkg::AddrWidth-1:0] pushAddr;
    logic [RasPkg::FetchIdWidth-1:0] queueRel;
    logic [RasPkg::FetchIdWidth-1:0] recRel;

    assign queueEmpty = qHead == qTail;
    assign queueFull = qHead == qTail + (RasPkg::QueueIdxWidth + 1)'(RasPkg::QueueDepth);
    assign qTop = rq[qHead[RasPkg::QueueIdxWidth-1:0] - 1'b1];
    assign qOld = rq[qTail[RasPkg::QueueIdxWidth-1:0]];

    assign head = evBuf[evRd];
    assign arrive = eventLink.valid && !misprValid;
    // Popping waits for a prediction credit so that output back-pressure reaches the input
    assign pop = evCount != '0 && !recovering && !misprValid && predCredit != '0;
    assign apply = pop && !evKill[evRd];
    assign isCall = head.btype == RasPkg::BrCall;
    assign isRet = head.btype == RasPkg::BrReturn;

    assign pushIdx = rIdx + 1'b1;
    assign pushAddr = {head.pc[RasPkg::AddrWidth-1:RasPkg::OffsWidth], head.offs} + 1'b1;

    always_comb begin
        nextIdx = rIdx;
        if (isCall) begin
            nextIdx = pushIdx;
        end else if (isRet) begin
            nextIdx = rIdx - 1'b1;
        end
    end

    // Fetch IDs wrap, so order is judged relative to the commit base
    assign queueRel = qTop.fetchId - recoveryBase;
    assign recRel = recoveryId - recoveryBase;
    assign restoreNow = !queueEmpty &&
        (queueRel > recRel || (queueRel == recRel && qTop.offs > recoveryOffs));

    assign predLink.valid = apply && isRet;
    assign predLink.payload = '{fetchId: head.fetchId, target: rstack[rIdx], stackIdx: rIdx};

    // An event discarded by a mispredict still hands its credit back
    assign eventLink.creditReturn = misprValid ? eventLink.valid : pop;
    assign eventLink.creditInit = RasPkg::CreditWidth'(RasPkg::LinkCredits);

    always_ff @(posedge clk) begin
        if (rst) begin
            rIdx <= '0;
            qHead <= '0;
            qTail <= '0;
            recovering <= 1'b0;
            lastComId <= '0;
            evRd <= '0;
            evWr <= '0;
            evCount <= '0;
            predCredit <= predLink.creditInit;
            for (int i = 0; i < RasPkg::StackDepth; i++) begin
                rstack[i] <= '0;
            end
        end else begin
            predCredit <= RasPkg::nextCredit(predCredit, predLink.valid, predLink.creditReturn);

            if (arrive) begin
                evBuf[evWr] <= eventLink.payload;
                evKill[evWr] <= 1'b0;
                evWr <= evWr + 1'b1;
            end
            if (pop) begin
                evRd <= evRd + 1'b1;
            end
            evCount <= evCount + RasPkg::CreditWidth'(arrive) - RasPkg::CreditWidth'(pop);

            if (misprValid) begin
                for (int i = 0; i < RasPkg::LinkCredits; i++) begin
                    evKill[i] <= 1'b1;
                end
                rIdx <= idxTable[misprId];
                recovering <= !queueEmpty;
                recoveryId <= misprId;
                recoveryBase <= lastComId;
                recoveryOffs <= misprOffs;
            end else if (recovering) begin
                // Copy back one overwritten entry per cycle starting with the newest
                if (restoreNow) begin
                    rstack[qTop.idx] <= qTop.addr;
                    qHead <= qHead - 1'b1;
                end else begin
                    recovering <= 1'b0;
                end
            end else if (apply) begin
                idxTable[head.fetchId] <= nextIdx;
                rIdx <= nextIdx;
                if (isCall) begin
                    rstack[pushIdx] <= pushAddr;
                    // With a full queue the overwritten address cannot be saved
                    if (!queueFull) begin
                        rq[qHead[RasPkg::QueueIdxWidth-1:0]] <= '{
                            addr: rstack[pushIdx],
                            idx: pushIdx,
                            fetchId: head.fetchId,
                            offs: head.offs
                        };
                        qHead <= qHead + 1'b1;
                    end
                end
            end

            // Retire the oldest entry once commit has moved past it
            if (!recovering && lastComId != commitId) begin
                if (!queueEmpty && (qOld.fetchId - lastComId) < (commitId - lastComId)) begin
                    lastComId <= qOld.fetchId;
                    qTail <= qTail + 1'b1;
                end else begin
                    lastComId <= commitId;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- runSim.sh
#!/usr/bin/env bash
# Builds the return predictor testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module ReturnPredictorTb \
    -f build.f -o simReturnPredictor > build.log 2>&1 \
    && ./obj_dir/simReturnPredictor > sim.log 2>&1 \
    || { cat build.log; echo "Simulation could not be built or run"; exit 1; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "Result: failed"; exit 1; }
echo "Result: passed"

//--- verification/ReturnPredictorTb.sv
`timescale 1ns/100ps
`default_nettype none

module ReturnPredictorTb;

    localparam int MaxRecords = 80;
    localparam int WaitLimit = 200;
    // Enough idle cycles for buffered events to reach the stack once the output drains
    localparam int SettleCycles = 8;

    logic clk;
    logic rst;
    logic inValid;
    logic inReady;
    logic [RasPkg::AddrWidth-1:0] inPc;
    logic [RasPkg::OffsWidth-1:0] inOffs;
    RasPkg::BranchType inType;
    logic [RasPkg::FetchIdWidth-1:0] commitId;
    logic misprValid;
    logic [RasPkg::FetchIdWidth-1:0] misprId;
    logic [RasPkg::OffsWidth-1:0] misprOffs;
    logic outValid;
    logic [RasPkg::AddrWidth-1:0] outTarget;
    logic [RasPkg::FetchIdWidth-1:0] outFetchId;
    logic outReady;

    // Each record is five words holding op, pc, offs, fetch ID and target
    logic [31:0] testData [5*MaxRecords];
    logic [31:0] lfsr;
    // Predictions handed out by the DUT with the fetch ID above the target
    logic [RasPkg::FetchIdWidth+RasPkg::AddrWidth-1:0] seen [$];
    int stallLeft;
    logic expectBp;
    logic sawBp;
    logic timedOut;
    int errors;
    int checks;
    int testErrors;
    int testChecks;

    ReturnPredictorTop u_ReturnPredictorTop (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inReady(inReady),
        .inPc(inPc),
        .inOffs(inOffs),
        .inType(inType),
        .commitId(commitId),
        .misprValid(misprValid),
        .misprId(misprId),
        .misprOffs(misprOffs),
        .outValid(outValid),
        .outTarget(outTarget),
        .outFetchId(outFetchId),
        .outReady(outReady)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst && outValid && outReady) begin
            seen.push_back({outFetchId, outTarget});
        end
    end

    function automatic logic [31:0] stepLfsr(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    task automatic noteError;
        errors++;
        testErrors++;
    endtask

    task automatic reportTest(input logic [7:0] testNum);
        $display("Test %0d finished with %0d checks and %0d errors",
                 testNum, testChecks, testErrors);
        testChecks = 0;
        testErrors = 0;
    endtask

    // Advances to the next falling edge and picks outReady for the new cycle
    task automatic nextCycle(input logic randomReady);
        @(negedge clk);
        if (stallLeft > 0) begin
            if (!inReady) begin
                sawBp = 1'b1;
            end
            stallLeft--;
            if (stallLeft == 0 && expectBp) begin
                checks++;
                testChecks++;
                if (!sawBp) begin
                    $display("[FAIL] %0t ns: inReady never fell while outReady was held low",
                             $time);
                    noteError();
                end
            end
        end
        if (stallLeft > 0) begin
            outReady = 1'b0;
        end else if (randomReady) begin
            lfsr = stepLfsr(lfsr);
            outReady = lfsr[0];
        end else begin
            outReady = 1'b1;
        end
    endtask

    task automatic settle;
        for (int i = 0; i < SettleCycles; i++) begin
            nextCycle(1'b0);
        end
    endtask

    task automatic pushEvent(input logic [31:0] pc, input logic [31:0] offs,
                             input logic [3:0] kind);
        int waited;
        logic taken;
        waited = 0;
        taken = 1'b0;
        inValid = 1'b1;
        inPc = pc[RasPkg::AddrWidth-1:0];
        inOffs = offs[RasPkg::OffsWidth-1:0];
        inType = RasPkg::BranchType'(kind[1:0]);
        while (!taken && waited < WaitLimit) begin
            taken = inReady;
            nextCycle(1'b1);
            waited++;
        end
        inValid = 1'b0;
        if (!taken) begin
            $display("Time %0t: the DUT did not accept an event within %0d cycles",
                     $time, WaitLimit);
            timedOut = 1'b1;
        end
    endtask

    task automatic mispredict(input logic [31:0] id, input logic [31:0] offs);
        settle();
        misprValid = 1'b1;
        misprId = id[RasPkg::FetchIdWidth-1:0];
        misprOffs = offs[RasPkg::OffsWidth-1:0];
        nextCycle(1'b0);
        misprValid = 1'b0;
    endtask

    task automatic commitTo(input logic [31:0] id);
        settle();
        commitId = id[RasPkg::FetchIdWidth-1:0];
        settle();
    endtask

    task automatic holdOutput(input logic [31:0] cycles, input logic mustStall);
        stallLeft = cycles;
        expectBp = mustStall;
        sawBp = 1'b0;
        if (cycles != 0) begin
            outReady = 1'b0;
        end
    endtask

    task automatic expectPrediction(input logic [31:0] id, input logic [31:0] target);
        int waited;
        logic [RasPkg::FetchIdWidth+RasPkg::AddrWidth-1:0] got;
        waited = 0;
        while (seen.size() == 0 && waited < WaitLimit) begin
            nextCycle(1'b0);
            waited++;
        end
        if (seen.size() == 0) begin
            $display("Time %0t: no prediction came out for fetch ID %0d", $time, id);
            timedOut = 1'b1;
        end else begin
            got = seen.pop_front();
            checks += 2;
            testChecks += 2;
            if (got[RasPkg::AddrWidth +: RasPkg::FetchIdWidth] !== id[RasPkg::FetchIdWidth-1:0]) begin
                $display("[FAIL] %0t ns: fetch ID is %0d, expected %0d", $time,
                         got[RasPkg::AddrWidth +: RasPkg::FetchIdWidth], id);
                noteError();
            end
            if (got[RasPkg::AddrWidth-1:0] !== target[RasPkg::AddrWidth-1:0]) begin
                $display("[FAIL] %0t ns: target for fetch ID %0d is %h, expected %h", $time, id,
                         got[RasPkg::AddrWidth-1:0], target[RasPkg::AddrWidth-1:0]);
                noteError();
            end
        end
    endtask

    initial begin
        int rec;
        int base;
        logic [31:0] opWord;
        logic [7:0] currentTest;
        logic running;
        rst = 1'b1;
        inValid = 1'b0;
        inPc = '0;
        inOffs = '0;
        inType = RasPkg::BrNone;
        commitId = '0;
        misprValid = 1'b0;
        misprId = '0;
        misprOffs = '0;
        outReady = 1'b0;
        lfsr = 32'he3fd_cddc;
        stallLeft = 0;
        expectBp = 1'b0;
        sawBp = 1'b0;
        timedOut = 1'b0;
        errors = 0;
        checks = 0;
        testErrors = 0;
        testChecks = 0;
        currentTest = 8'd0;
        $readmemh("verification/rasTestdata.mem", testData);
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        rec = 0;
        running = 1'b1;
        while (running && !timedOut && rec < MaxRecords) begin
            base = rec * 5;
            opWord = testData[base];
            if (opWord[15:8] != currentTest) begin
                if (currentTest != 8'd0) begin
                    reportTest(currentTest);
                end
                currentTest = opWord[15:8];
            end
            case (opWord[7:4])
                4'h0: running = 1'b0;
                4'h1: pushEvent(testData[base+1], testData[base+2], opWord[3:0]);
                4'h2: mispredict(testData[base+3], testData[base+2]);
                4'h3: commitTo(testData[base+3]);
                4'h4: expectPrediction(testData[base+3], testData[base+4]);
                4'h5: holdOutput(testData[base+1], testData[base+4][0]);
                default: begin
                    $display("Unknown operation code %h in record %0d", opWord, rec);
                    noteError();
                    running = 1'b0;
                end
            endcase
            rec++;
        end

        // Any prediction left over once the output has drained was never expected
        if (!timedOut) begin
            settle();
            checks++;
            testChecks++;
            if (seen.size() != 0) begin
                $display("[FAIL] %0t ns: %0d predictions came out that no record expected",
                         $time, seen.size());
                noteError();
            end
        end
        if (currentTest != 8'd0) begin
            reportTest(currentTest);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timedOut) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/rasTestdata.mem
// Columns (hex): op pc offs fetchId target. Op is test number, operation, branch type
// Operations: 1 push, 2 mispredict, 3 commit, 4 read, 5 stall (pc = cycles, target = 1 if inReady must fall)
0111 00001000 2 00 00000000
0112 00002000 0 00 00000000
0140 00000000 0 01 00001003
0212 00002100 0 00 00000000
0211 00000100 0 00 00000000
0211 00000200 0 00 00000000
0211 00000300 0 00 00000000
0211 00000400 0 00 00000000
0211 00000500 0 00 00000000
0211 00000600 0 00 00000000
0211 00000700 0 00 00000000
0211 00000800 0 00 00000000
0212 00003000 0 00 00000000
0212 00003000 0 00 00000000
0212 00003000 0 00 00000000
0212 00003000 0 00 00000000
0212 00003000 0 00 00000000
0212 00003000 0 00 00000000
0212 00003000 0 00 00000000
0212 00003000 0 00 00000000
0240 00000000 0 02 00000000
0240 00000000 0 0b 00000801
0240 00000000 0 0c 00000701
0240 00000000 0 0d 00000601
0240 00000000 0 0e 00000501
0240 00000000 0 0f 00000401
0240 00000000 0 10 00000301
0240 00000000 0 11 00000201
0240 00000000 0 12 00000101
0330 00000000 0 13 00000000
0311 00004000 1 00 00000000
0312 00002400 0 00 00000000
0312 00002400 0 00 00000000
0311 00005000 0 00 00000000
0311 00006000 3 00 00000000
0340 00000000 0 14 00004002
0340 00000000 0 15 00000801
0320 00000000 1 13 00000000
0312 00002800 0 00 00000000
0312 00002800 0 00 00000000
0312 00002800 0 00 00000000
0340 00000000 0 14 00004002
0340 00000000 0 15 00000801
0340 00000000 0 16 00000701
0411 00007000 2 00 00000000
0411 00008000 0 00 00000000
0430 00000000 0 19 00000000
0420 00000000 0 18 00000000
0412 00002c00 0 00 00000000
0412 00002c00 0 00 00000000
0412 00002c00 0 00 00000000
0440 00000000 0 19 00008001
0440 00000000 0 1a 00007003
0440 00000000 0 1b 00000601
0550 00000028 0 00 00000001
0512 00003400 0 00 00000000
0512 00003400 0 00 00000000
0512 00003400 0 00 00000000
0512 00003400 0 00 00000000
0512 00003400 0 00 00000000
0512 00003400 0 00 00000000
0512 00003400 0 00 00000000
0540 00000000 0 1c 00000501
0540 00000000 0 1d 00000401
0540 00000000 0 1e 00000301
0540 00000000 0 1f 00000201
0540 00000000 0 00 00004002
0540 00000000 0 01 00008001
0540 00000000 0 02 00007003
0620 00000000 0 1f 00000000
0612 00003800 0 00 00000000
0611 00009000 1 00 00000000
0612 00003800 0 00 00000000
0640 00000000 0 00 00004002
0640 00000000 0 02 00009002
0000 00000000 0 00 00000000
